// File: Makefile
TOP := pio_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/100ps -f vlog.f \
		--top-module $(TOP) -o V$(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "Simulation finished: PASS"

lint:
	verilator --lint-only --timing -Wall --timescale 1ns/100ps -f vlog.f \
		--top-module pio_top

clean:
	rm -rf obj_dir

// File: bench/pio_tb.sv
// Directed testbench for the PIO target, run as top module pio_tb from the file list
`timescale 1ns/100ps
`include "pio_consts.svh"

module pio_tb;

    localparam int          NUM_TLPS   = 32;
    localparam int          MAX_CYCLES = 40 * NUM_TLPS + 20;   // Reset included
    localparam logic [15:0] CPL_ID     = 16'h0150;

    logic                    clk;
    logic                    nrst;
    logic [`PIO_DATA_W-1:0]  rx_tdata;
    logic [`PIO_KEEP_W-1:0]  rx_tkeep;
    logic                    rx_tlast;
    logic                    rx_tvalid;
    logic [`PIO_TUSER_W-1:0] rx_tuser;
    logic                    rx_tready;
    logic [`PIO_DATA_W-1:0]  tx_tdata;
    logic [`PIO_KEEP_W-1:0]  tx_tkeep;
    logic                    tx_tlast;
    logic                    tx_tvalid;
    logic                    tx_tready;

    logic [7:0]  ref_mem [0:8191];      // Byte model indexed by {region, byte offset}
    logic [31:0] rng;
    logic        bp_on;
    int          cycles = 0;
    logic [2:0]  cur_tc;
    logic [1:0]  cur_td_ep;
    logic [1:0]  cur_attr;
    logic [15:0] cur_rid;
    logic [7:0]  cur_tag;

    pio_top u_pio_top (
        .i_clk              (clk),
        .i_nrst             (nrst),
        .i_cfg_completer_id (CPL_ID),
        .i_rx_tdata         (rx_tdata),
        .i_rx_tkeep         (rx_tkeep),
        .i_rx_tlast         (rx_tlast),
        .i_rx_tvalid        (rx_tvalid),
        .i_rx_tuser         (rx_tuser),
        .o_rx_tready        (rx_tready),
        .o_tx_tdata         (tx_tdata),
        .o_tx_tkeep         (tx_tkeep),
        .o_tx_tlast         (tx_tlast),
        .o_tx_tvalid        (tx_tvalid),
        .i_tx_tready        (tx_tready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            stop_with_failure($sformatf("Timeout, no end of test after %0d cycles", MAX_CYCLES));
        end
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at %0t ns", $time);
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAILED at %0t ns: %s got 0x%0h expected 0x%0h",
                                        $time, name, got, exp));
        end
    endtask

    task automatic compare_kind(input string name, input pio_pkg::resp_kind_e got,
                                input pio_pkg::resp_kind_e exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAILED at %0t ns: %s got %s expected %s",
                                        $time, name, got.name(), exp.name()));
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic logic [`PIO_TUSER_W-1:0] bar_hit(input logic [1:0] region);
        case (region)
            2'd1:    return 9'h004;             // Mem32 BAR
            2'd2:    return 9'h008;             // Mem64 BAR
            2'd3:    return 9'h100;             // Expansion ROM
            default: return 9'h000;
        endcase
    endfunction

    function automatic pio_pkg::resp_kind_e kind_of_fmt(input logic [7:0] fmt);
        if (fmt == `PIO_CPLD_FMT) begin
            return pio_pkg::RESP_CPLD;
        end else if (fmt == `PIO_CPL_FMT) begin
            return pio_pkg::RESP_CPL;
        end else begin
            return pio_pkg::RESP_NONE;
        end
    endfunction

    function automatic logic [31:0] count_bits(input logic [3:0] be);
        count_bits = 32'h0;
        for (int k = 0; k < 4; k++) begin
            count_bits += 32'(be[k]);
        end
    endfunction

    // Lowest enabled byte gives the low bits of the lower address
    function automatic logic [1:0] lead_offset(input logic [3:0] be);
        lead_offset = 2'd0;
        for (int k = 3; k >= 0; k--) begin
            if (be[k]) begin
                lead_offset = 2'(k);
            end
        end
    endfunction

    task automatic merge_into_model(input logic [1:0] region, input logic [10:0] addr,
                                    input logic [3:0] be, input logic [31:0] data);
        int base;
        base = int'({region, addr[10:2], 2'b00});
        for (int k = 0; k < 4; k++) begin
            if (be[k]) begin
                ref_mem[base + k] = data[8*k +: 8];
            end
        end
    endtask

    function automatic logic [31:0] expected_dword(input logic [1:0] region,
                                                   input logic [10:0] addr);
        int base;
        base = int'({region, addr[10:2], 2'b00});
        return {ref_mem[base + 3], ref_mem[base + 2], ref_mem[base + 1], ref_mem[base]};
    endfunction

    task automatic push_beat(input logic [63:0] data, input logic [7:0] keep, input logic last);
        rx_tdata  = data;
        rx_tkeep  = keep;
        rx_tlast  = last;
        rx_tvalid = 1'b1;
        while (!rx_tready) @(negedge clk);
        @(negedge clk);                         // Taken on the rising edge in between
    endtask

    // Header dwords, address dwords and payload packed two per beat
    task automatic send_tlp(input logic [6:0] op, input logic [9:0] len, input logic [1:0] region,
                            input logic [10:0] addr, input logic [3:0] be,
                            input logic [31:0] data);
        logic [31:0] dws [$];
        logic [31:0] r;
        r         = next_rand();
        cur_tc    = r[2:0];
        cur_attr  = r[5:4];
        cur_td_ep = r[7:6];
        cur_tag   = r[15:8];
        cur_rid   = r[31:16];
        dws.push_back({1'b0, op, 1'b0, cur_tc, 4'h0, cur_td_ep, cur_attr, 2'b00, len});
        dws.push_back({cur_rid, cur_tag, (len > 10'd1) ? 4'hF : 4'h0, be});
        if (op[5]) begin
            dws.push_back(32'h0);               // Upper address of a 4DW header
        end
        dws.push_back({21'h0, addr[10:2], 2'b00});
        if (op[6]) begin
            for (int k = 0; k < int'(len); k++) begin
                dws.push_back(data + 32'(k));
            end
        end
        rx_tuser = bar_hit(region);
        while (dws.size() > 0) begin
            if (dws.size() >= 2) begin
                push_beat({dws[1], dws[0]}, 8'hFF, dws.size() == 2);
                void'(dws.pop_front());
                void'(dws.pop_front());
            end else begin
                push_beat({32'h0, dws[0]}, 8'h0F, 1'b1);
                void'(dws.pop_front());
            end
        end
        rx_tvalid = 1'b0;
        rx_tlast  = 1'b0;
    endtask

    task automatic collect_cpl(output logic [63:0] b0, output logic [63:0] b1,
                               output logic [7:0] k1);
        int          n;
        logic [31:0] r;
        n = 0;
        while (n < 2) begin
            r         = next_rand();
            tx_tready = r[0] || !bp_on;
            if (tx_tvalid && tx_tready) begin
                compare_field("o_tx_tlast", 32'(tx_tlast), 32'(n));
                if (n == 0) begin
                    b0 = tx_tdata;
                end else begin
                    b1 = tx_tdata;
                    k1 = tx_tkeep;
                end
                n++;
            end
            @(negedge clk);
        end
        tx_tready = 1'b0;
    endtask

    task automatic verify_completion(input pio_pkg::resp_kind_e kind, input logic [1:0] region,
                                     input logic [10:0] addr, input logic [3:0] be,
                                     input logic [63:0] b0, input logic [63:0] b1,
                                     input logic [7:0] k1);
        logic has_data;
        has_data = (kind == pio_pkg::RESP_CPLD);
        compare_kind("fmt_type", kind_of_fmt(b0[31:24]), kind);
        compare_field("length", 32'(b0[9:0]), has_data ? 32'd1 : 32'd0);
        compare_field("tc", 32'(b0[22:20]), 32'(cur_tc));
        compare_field("td_ep", 32'(b0[15:14]), 32'(cur_td_ep));
        compare_field("attr", 32'(b0[13:12]), 32'(cur_attr));
        compare_field("completer_id", 32'(b0[63:48]), 32'(CPL_ID));
        compare_field("status", 32'(b0[47:45]), 32'h0);
        compare_field("byte_count", 32'(b0[43:32]), count_bits(be));
        compare_field("requester_id", 32'(b1[31:16]), 32'(cur_rid));
        compare_field("tag", 32'(b1[15:8]), 32'(cur_tag));
        compare_field("lower_addr", 32'(b1[6:0]), {25'h0, addr[6:2], lead_offset(be)});
        compare_field("o_tx_tkeep", 32'(k1), has_data ? 32'hFF : 32'h0F);
        if (has_data) begin
            compare_field("data", b1[63:32], expected_dword(region, addr));
        end
    endtask

    task automatic post_write(input logic [6:0] op, input logic [1:0] region,
                              input logic [10:0] addr, input logic [3:0] be,
                              input logic [31:0] data);
        send_tlp(op, 10'd1, region, addr, be, data);
        merge_into_model(region, addr, be, data);
        while (!rx_tready) @(negedge clk);      // Posted write is over
        compare_field("o_tx_tvalid", 32'(tx_tvalid), 32'h0);
    endtask

    task automatic read_back(input logic [6:0] op, input logic [1:0] region,
                             input logic [10:0] addr, input logic [3:0] be);
        logic [63:0] b0;
        logic [63:0] b1;
        logic [7:0]  k1;
        send_tlp(op, 10'd1, region, addr, be, 32'h0);
        collect_cpl(b0, b1, k1);
        verify_completion(pio_pkg::RESP_CPLD, region, addr, be, b0, b1, k1);
    endtask

    task automatic io_write(input logic [1:0] region, input logic [10:0] addr,
                            input logic [31:0] data);
        logic [63:0] b0;
        logic [63:0] b1;
        logic [7:0]  k1;
        send_tlp(pio_pkg::IOWR32, 10'd1, region, addr, 4'hF, data);
        merge_into_model(region, addr, 4'hF, data);
        collect_cpl(b0, b1, k1);
        verify_completion(pio_pkg::RESP_CPL, region, addr, 4'hF, b0, b1, k1);
    endtask

    task automatic drop_tlp(input logic [6:0] op, input logic [9:0] len,
                            input logic [1:0] region, input logic [10:0] addr);
        send_tlp(op, len, region, addr, 4'hF, next_rand());
        repeat (4) @(negedge clk);              // A completion would be up by now
        compare_field("o_tx_tvalid", 32'(tx_tvalid), 32'h0);
        compare_field("o_rx_tready", 32'(rx_tready), 32'h1);
    endtask

    task automatic mem32_roundtrip();
        post_write(pio_pkg::MWR32, 2'd1, 11'h010, 4'hF, next_rand());
        post_write(pio_pkg::MWR32, 2'd1, 11'h014, 4'hF, next_rand());
        read_back(pio_pkg::MRD32, 2'd1, 11'h014, 4'hF);
        read_back(pio_pkg::MRD32, 2'd1, 11'h010, 4'hF);
    endtask

    task automatic mem64_regions();
        post_write(pio_pkg::MWR64, 2'd2, 11'h010, 4'hF, next_rand());
        read_back(pio_pkg::MRD64, 2'd2, 11'h010, 4'hF);
        read_back(pio_pkg::MRD32, 2'd1, 11'h010, 4'hF);   // Same offset in the other region
    endtask

    task automatic io_roundtrip();
        io_write(2'd0, 11'h020, next_rand());
        read_back(pio_pkg::IORD32, 2'd0, 11'h020, 4'hF);
    endtask

    task automatic partial_strobes();
        post_write(pio_pkg::MWR32, 2'd1, 11'h034, 4'hF, next_rand());
        post_write(pio_pkg::MWR32, 2'd1, 11'h034, 4'b0101, next_rand());
        read_back(pio_pkg::MRD32, 2'd1, 11'h034, 4'hF);
        read_back(pio_pkg::MRD32, 2'd1, 11'h034, 4'b1100);
    endtask

    task automatic random_backpressure();
        logic [31:0] r;
        logic [1:0]  region;
        logic [10:0] addr;
        logic [3:0]  be;
        bp_on = 1'b1;
        repeat (8) begin
            r      = next_rand();
            region = 2'd1 + 2'(r[0]);
            addr   = {r[12:4], 2'b00};
            be     = (r[19:16] == 4'h0) ? 4'h1 : r[19:16];
            post_write(r[20] ? pio_pkg::MWR64 : pio_pkg::MWR32, region, addr, 4'hF, next_rand());
            read_back(r[21] ? pio_pkg::MRD64 : pio_pkg::MRD32, region, addr, be);
        end
        bp_on = 1'b0;
    endtask

    task automatic dropped_tlps();
        drop_tlp(pio_pkg::MWR32, 10'd2, 2'd1, 11'h010);   // Two dwords long
        drop_tlp(7'h04, 10'd1, 2'd1, 11'h010);            // Config read type
        read_back(pio_pkg::MRD32, 2'd1, 11'h010, 4'hF);
    endtask

    initial begin
        nrst      = 1'b0;
        rx_tdata  = '0;
        rx_tkeep  = '0;
        rx_tlast  = 1'b0;
        rx_tvalid = 1'b0;
        rx_tuser  = '0;
        tx_tready = 1'b0;
        rng       = 32'h7fb5e733;
        bp_on     = 1'b0;
        repeat (10) @(negedge clk);
        nrst = 1'b1;
        mem32_roundtrip();
        mem64_regions();
        io_roundtrip();
        partial_strobes();
        random_backpressure();
        dropped_tlps();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: verilog/pio_consts.svh
// Widths and completion codes shared by the PIO target RTL and its testbench
`ifndef PIO_CONSTS_SVH
`define PIO_CONSTS_SVH

`define PIO_DATA_W   64         // Stream data width
`define PIO_KEEP_W   8          // One keep bit per data byte
`define PIO_TUSER_W  9          // BAR hit vector sits in bits 8:2
`define PIO_ADDR_W   13         // Region, dword index, byte offset
`define PIO_MEM_AW   10         // 64-bit word index from address bits 12:3

`define PIO_CPL_FMT  8'h0A      // Completion without data
`define PIO_CPLD_FMT 8'h4A      // Completion with data

`endif

// File: verilog/pio_mem_target.sv
// Byte-strobed memory behind the PIO target, serving one request at a time
`timescale 1ns/100ps
`include "pio_consts.svh"

module pio_mem_target (
    input  logic                   i_clk,
    input  logic                   i_nrst,
    input  logic                   i_req_valid,
    input  logic                   i_req_write,
    input  logic [`PIO_ADDR_W-1:0] i_req_addr,
    input  logic [`PIO_KEEP_W-1:0] i_req_strob,
    input  logic [`PIO_DATA_W-1:0] i_req_data,
    output logic                   o_req_ready,
    output logic                   o_resp_valid,
    output logic [`PIO_DATA_W-1:0] o_resp_data
);

    logic [`PIO_DATA_W-1:0] mem [0:(2**`PIO_MEM_AW)-1];   // Regions share one array
    logic [`PIO_MEM_AW-1:0] word_idx;
    logic                   accept;

    assign word_idx    = i_req_addr[`PIO_ADDR_W-1:3];
    assign o_req_ready = !o_resp_valid;                   // Busy while answering
    assign accept      = i_req_valid && o_req_ready;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_resp_valid <= 1'b0;
        end else begin
            o_resp_valid <= accept;
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            if (i_req_write) begin
                for (int i = 0; i < `PIO_KEEP_W; i++) begin
                    if (i_req_strob[i]) begin
                        mem[word_idx][8*i +: 8] <= i_req_data[8*i +: 8];
                    end
                end
                o_resp_data <= '0;                        // Write ack carries no data
            end else begin
                o_resp_data <= mem[word_idx];
            end
        end
    end

    a_resp_pulse: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_resp_valid |=> !o_resp_valid)
        else $error("response held longer than one cycle");

endmodule

// File: verilog/pio_pkg.sv
// Types for the PIO target; RTL and testbench refer to them by scoped name
package pio_pkg;

    typedef enum logic [6:0] {
        MRD32  = 7'h00,
        MWR32  = 7'h40,
        MRD64  = 7'h20,
        MWR64  = 7'h60,
        IORD32 = 7'h02,
        IOWR32 = 7'h42
    } fmt_type_e;

    typedef enum logic [3:0] {
        RX_IDLE,
        RX_RD32_DW1,                // MRd32 and IORd32 address beat
        RX_WR32_DW1,                // Address and data
        RX_RD64_DW1,
        RX_WR64_DW1,                // Address only, data follows
        RX_WR64_DW3,
        RX_IOWR_DW1,
        RX_WAIT_RESP,               // Memory target busy
        RX_WAIT_CPL                 // Completion on its way out
    } rx_state_e;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_HDR0,                    // Header dwords 0 and 1
        TX_HDR1                     // Header dword 2 and data
    } tx_state_e;

    typedef enum logic [1:0] {
        RESP_NONE,                  // Posted write
        RESP_CPL,
        RESP_CPLD
    } resp_kind_e;

endpackage

// File: verilog/pio_rx_engine.sv
// Receive engine: turns single-dword PIO TLPs into memory and completion requests
`timescale 1ns/100ps
`include "pio_consts.svh"

module pio_rx_engine (
    input  logic                    i_clk,
    input  logic                    i_nrst,
    input  logic [`PIO_DATA_W-1:0]  i_rx_tdata,
    input  logic [`PIO_KEEP_W-1:0]  i_rx_tkeep,
    input  logic                    i_rx_tlast,
    input  logic                    i_rx_tvalid,
    input  logic [`PIO_TUSER_W-1:0] i_rx_tuser,
    output logic                    o_rx_tready,
    input  logic                    i_req_ready,
    output logic                    o_req_valid,
    output logic                    o_req_write,
    output logic [`PIO_ADDR_W-1:0]  o_req_addr,
    output logic [`PIO_KEEP_W-1:0]  o_req_strob,
    output logic [`PIO_DATA_W-1:0]  o_req_data,
    input  logic                    i_resp_valid,
    input  logic                    i_compl_done,
    output pio_pkg::resp_kind_e     o_cpl_kind,
    output logic [2:0]              o_cpl_tc,
    output logic                    o_cpl_td,
    output logic                    o_cpl_ep,
    output logic [1:0]              o_cpl_attr,
    output logic [15:0]             o_cpl_rid,
    output logic [7:0]              o_cpl_tag,
    output logic [2:0]              o_cpl_bytes,
    output logic [`PIO_ADDR_W-1:0]  o_cpl_addr
);

    pio_pkg::rx_state_e  state;
    pio_pkg::fmt_type_e  hdr_fmt;
    pio_pkg::resp_kind_e last_kind;
    logic                beat;
    logic                sop;               // Next accepted beat opens a TLP
    logic                hdr_ok;
    logic                dw_lo_ok;
    logic                dw_hi_ok;
    logic [1:0]          hit_region;
    logic [1:0]          region;
    logic [3:0]          first_be;
    logic [1:0]          be_off;

    // Place the dword's byte enables in the half picked by address bit 2
    function automatic logic [7:0] lane_strob(input logic hi, input logic [3:0] be);
        lane_strob = hi ? {be, 4'h0} : {4'h0, be};
    endfunction

    assign beat       = i_rx_tvalid && o_rx_tready;
    assign hdr_fmt    = pio_pkg::fmt_type_e'(i_rx_tdata[30:24]);
    assign hdr_ok     = sop && (i_rx_tdata[9:0] == 10'd1);   // Only 1DW requests are served
    assign dw_lo_ok   = &i_rx_tkeep[3:0];
    assign dw_hi_ok   = &i_rx_tkeep[7:4];
    assign o_cpl_addr = o_req_addr;

    always_comb begin
        case (i_rx_tuser[8:2])
            7'h01:   hit_region = 2'd1;                      // Mem32 BAR
            7'h02:   hit_region = 2'd2;                      // Mem64 BAR
            7'h40:   hit_region = 2'd3;                      // Expansion ROM
            default: hit_region = 2'd0;
        endcase

        if (first_be[0]) begin
            be_off = 2'd0;
        end else if (first_be[1]) begin
            be_off = 2'd1;
        end else if (first_be[2]) begin
            be_off = 2'd2;
        end else begin
            be_off = 2'd3;
        end

        case (state)
            pio_pkg::RX_RD32_DW1, pio_pkg::RX_RD64_DW1: last_kind = pio_pkg::RESP_CPLD;
            pio_pkg::RX_IOWR_DW1:                       last_kind = pio_pkg::RESP_CPL;
            default:                                    last_kind = pio_pkg::RESP_NONE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state       <= pio_pkg::RX_IDLE;
            sop         <= 1'b1;
            o_rx_tready <= 1'b0;
            o_req_valid <= 1'b0;
            o_cpl_kind  <= pio_pkg::RESP_NONE;
        end else begin
            if (beat) begin
                sop <= i_rx_tlast;                           // Tail beats of dropped TLPs skip decode
            end
            case (state)
                pio_pkg::RX_IDLE: begin
                    o_rx_tready <= 1'b1;
                    if (beat && hdr_ok) begin
                        case (hdr_fmt)
                            pio_pkg::MRD32, pio_pkg::IORD32: state <= pio_pkg::RX_RD32_DW1;
                            pio_pkg::MWR32:                  state <= pio_pkg::RX_WR32_DW1;
                            pio_pkg::MRD64:                  state <= pio_pkg::RX_RD64_DW1;
                            pio_pkg::MWR64:                  state <= pio_pkg::RX_WR64_DW1;
                            pio_pkg::IOWR32:                 state <= pio_pkg::RX_IOWR_DW1;
                            default:                         state <= pio_pkg::RX_IDLE;
                        endcase
                    end
                end
                pio_pkg::RX_WR64_DW1: begin
                    if (beat) begin
                        state <= pio_pkg::RX_WR64_DW3;
                    end
                end
                pio_pkg::RX_WAIT_RESP: begin
                    if (i_req_ready) begin
                        o_req_valid <= 1'b0;
                    end
                    if (i_resp_valid) begin
                        if (o_cpl_kind == pio_pkg::RESP_NONE) begin
                            o_rx_tready <= 1'b1;             // Posted write is finished
                            state       <= pio_pkg::RX_IDLE;
                        end else begin
                            state <= pio_pkg::RX_WAIT_CPL;
                        end
                    end
                end
                pio_pkg::RX_WAIT_CPL: begin
                    if (i_compl_done) begin
                        o_rx_tready <= 1'b1;
                        o_cpl_kind  <= pio_pkg::RESP_NONE;
                        state       <= pio_pkg::RX_IDLE;
                    end
                end
                default: begin                               // Beat that ends the request
                    if (beat) begin
                        o_rx_tready <= 1'b0;
                        o_req_valid <= 1'b1;
                        o_cpl_kind  <= last_kind;
                        state       <= pio_pkg::RX_WAIT_RESP;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (beat) begin
            case (state)
                pio_pkg::RX_IDLE: begin
                    o_cpl_tc    <= i_rx_tdata[22:20];
                    o_cpl_td    <= i_rx_tdata[15];
                    o_cpl_ep    <= i_rx_tdata[14];
                    o_cpl_attr  <= i_rx_tdata[13:12];
                    o_cpl_rid   <= i_rx_tdata[63:48];
                    o_cpl_tag   <= i_rx_tdata[47:40];
                    first_be    <= i_rx_tdata[35:32];
                    o_cpl_bytes <= 3'(i_rx_tdata[32]) + 3'(i_rx_tdata[33])
                                 + 3'(i_rx_tdata[34]) + 3'(i_rx_tdata[35]);
                    region      <= hit_region;
                end
                pio_pkg::RX_RD32_DW1, pio_pkg::RX_WR32_DW1, pio_pkg::RX_IOWR_DW1: begin
                    o_req_addr  <= {region, i_rx_tdata[10:2], be_off};
                    o_req_write <= (state != pio_pkg::RX_RD32_DW1);
                    o_req_strob <= lane_strob(i_rx_tdata[2], first_be) & {8{dw_hi_ok}};
                    o_req_data  <= {2{i_rx_tdata[63:32]}};
                end
                pio_pkg::RX_RD64_DW1, pio_pkg::RX_WR64_DW1: begin
                    o_req_addr  <= {region, i_rx_tdata[42:34], be_off};
                    o_req_write <= (state == pio_pkg::RX_WR64_DW1);
                    o_req_strob <= lane_strob(i_rx_tdata[34], first_be);
                end
                pio_pkg::RX_WR64_DW3: begin
                    o_req_strob <= o_req_strob & {8{dw_lo_ok}};   // Data dword in low lane
                    o_req_data  <= {2{i_rx_tdata[31:0]}};
                end
                default: begin
                end
            endcase
        end
    end

    // Request must not change until the memory target takes it
    a_req_stable: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_req_valid && !i_req_ready |=> o_req_valid
            && $stable({o_req_write, o_req_addr, o_req_strob, o_req_data}))
        else $error("memory request changed before acceptance");

endmodule

// File: verilog/pio_top.sv
// PIO target top: receive engine, memory target and transmit engine on AXI-Stream
`timescale 1ns/100ps
`include "pio_consts.svh"

module pio_top (
    input  logic                    i_clk,
    input  logic                    i_nrst,
    input  logic [15:0]             i_cfg_completer_id,
    input  logic [`PIO_DATA_W-1:0]  i_rx_tdata,
    input  logic [`PIO_KEEP_W-1:0]  i_rx_tkeep,
    input  logic                    i_rx_tlast,
    input  logic                    i_rx_tvalid,
    input  logic [`PIO_TUSER_W-1:0] i_rx_tuser,
    output logic                    o_rx_tready,
    output logic [`PIO_DATA_W-1:0]  o_tx_tdata,
    output logic [`PIO_KEEP_W-1:0]  o_tx_tkeep,
    output logic                    o_tx_tlast,
    output logic                    o_tx_tvalid,
    input  logic                    i_tx_tready
);

    logic                   req_valid;
    logic                   req_ready;
    logic                   req_write;
    logic [`PIO_ADDR_W-1:0] req_addr;
    logic [`PIO_KEEP_W-1:0] req_strob;
    logic [`PIO_DATA_W-1:0] req_data;
    logic                   resp_valid;
    logic [`PIO_DATA_W-1:0] resp_data;
    logic                   compl_done;
    pio_pkg::resp_kind_e    cpl_kind;
    logic [2:0]             cpl_tc;
    logic                   cpl_td;
    logic                   cpl_ep;
    logic [1:0]             cpl_attr;
    logic [15:0]            cpl_rid;
    logic [7:0]             cpl_tag;
    logic [2:0]             cpl_bytes;
    logic [`PIO_ADDR_W-1:0] cpl_addr;

    pio_rx_engine u_rx (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_rx_tdata   (i_rx_tdata),
        .i_rx_tkeep   (i_rx_tkeep),
        .i_rx_tlast   (i_rx_tlast),
        .i_rx_tvalid  (i_rx_tvalid),
        .i_rx_tuser   (i_rx_tuser),
        .o_rx_tready  (o_rx_tready),
        .i_req_ready  (req_ready),
        .o_req_valid  (req_valid),
        .o_req_write  (req_write),
        .o_req_addr   (req_addr),
        .o_req_strob  (req_strob),
        .o_req_data   (req_data),
        .i_resp_valid (resp_valid),
        .i_compl_done (compl_done),
        .o_cpl_kind   (cpl_kind),
        .o_cpl_tc     (cpl_tc),
        .o_cpl_td     (cpl_td),
        .o_cpl_ep     (cpl_ep),
        .o_cpl_attr   (cpl_attr),
        .o_cpl_rid    (cpl_rid),
        .o_cpl_tag    (cpl_tag),
        .o_cpl_bytes  (cpl_bytes),
        .o_cpl_addr   (cpl_addr)
    );

    pio_mem_target u_mem (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_req_valid  (req_valid),
        .i_req_write  (req_write),
        .i_req_addr   (req_addr),
        .i_req_strob  (req_strob),
        .i_req_data   (req_data),
        .o_req_ready  (req_ready),
        .o_resp_valid (resp_valid),
        .o_resp_data  (resp_data)
    );

    pio_tx_engine u_tx (
        .i_clk              (i_clk),
        .i_nrst             (i_nrst),
        .i_cfg_completer_id (i_cfg_completer_id),
        .i_cpl_kind         (cpl_kind),
        .i_cpl_tc           (cpl_tc),
        .i_cpl_td           (cpl_td),
        .i_cpl_ep           (cpl_ep),
        .i_cpl_attr         (cpl_attr),
        .i_cpl_rid          (cpl_rid),
        .i_cpl_tag          (cpl_tag),
        .i_cpl_bytes        (cpl_bytes),
        .i_cpl_addr         (cpl_addr),
        .i_resp_valid       (resp_valid),
        .i_resp_data        (resp_data),
        .i_tx_tready        (i_tx_tready),
        .o_tx_tdata         (o_tx_tdata),
        .o_tx_tkeep         (o_tx_tkeep),
        .o_tx_tlast         (o_tx_tlast),
        .o_tx_tvalid        (o_tx_tvalid),
        .o_compl_done       (compl_done)
    );

endmodule

// File: verilog/pio_tx_engine.sv
// Transmit engine: sends the 3DW Cpl or CplD for a finished PIO request
`timescale 1ns/100ps
`include "pio_consts.svh"

module pio_tx_engine (
    input  logic                   i_clk,
    input  logic                   i_nrst,
    input  logic [15:0]            i_cfg_completer_id,
    input  pio_pkg::resp_kind_e    i_cpl_kind,
    input  logic [2:0]             i_cpl_tc,
    input  logic                   i_cpl_td,
    input  logic                   i_cpl_ep,
    input  logic [1:0]             i_cpl_attr,
    input  logic [15:0]            i_cpl_rid,
    input  logic [7:0]             i_cpl_tag,
    input  logic [2:0]             i_cpl_bytes,
    input  logic [`PIO_ADDR_W-1:0] i_cpl_addr,
    input  logic                   i_resp_valid,
    input  logic [`PIO_DATA_W-1:0] i_resp_data,
    input  logic                   i_tx_tready,
    output logic [`PIO_DATA_W-1:0] o_tx_tdata,
    output logic [`PIO_KEEP_W-1:0] o_tx_tkeep,
    output logic                   o_tx_tlast,
    output logic                   o_tx_tvalid,
    output logic                   o_compl_done
);

    pio_pkg::tx_state_e state;
    logic [31:0]        data_dw;
    logic               is_cpld;
    logic [7:0]         fmt;
    logic [6:0]         lower_addr;
    logic [31:0]        hdr_dw0;
    logic [31:0]        hdr_dw1;
    logic [31:0]        hdr_dw2;

    assign is_cpld    = (i_cpl_kind == pio_pkg::RESP_CPLD);
    assign fmt        = is_cpld ? `PIO_CPLD_FMT : `PIO_CPL_FMT;
    assign lower_addr = i_cpl_addr[6:0];                  // Low bits already from first BE

    // Length is one dword for CplD and zero for Cpl, status is always successful
    assign hdr_dw0 = {fmt, 1'b0, i_cpl_tc, 4'h0, i_cpl_td, i_cpl_ep, i_cpl_attr,
                      2'b00, 9'd0, is_cpld};
    assign hdr_dw1 = {i_cfg_completer_id, 3'b000, 1'b0, 9'd0, i_cpl_bytes};
    assign hdr_dw2 = {i_cpl_rid, i_cpl_tag, 1'b0, lower_addr};

    assign o_tx_tvalid = (state != pio_pkg::TX_IDLE);
    assign o_tx_tlast  = (state == pio_pkg::TX_HDR1);

    always_comb begin
        if (state == pio_pkg::TX_HDR1) begin
            o_tx_tdata = {is_cpld ? data_dw : 32'h0, hdr_dw2};
            o_tx_tkeep = is_cpld ? 8'hFF : 8'h0F;
        end else begin
            o_tx_tdata = {hdr_dw1, hdr_dw0};
            o_tx_tkeep = 8'hFF;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state        <= pio_pkg::TX_IDLE;
            o_compl_done <= 1'b0;
        end else begin
            o_compl_done <= 1'b0;
            case (state)
                pio_pkg::TX_IDLE: begin
                    if (i_resp_valid && i_cpl_kind != pio_pkg::RESP_NONE) begin
                        state <= pio_pkg::TX_HDR0;
                    end
                end
                pio_pkg::TX_HDR0: begin
                    if (i_tx_tready) begin
                        state <= pio_pkg::TX_HDR1;
                    end
                end
                default: begin
                    if (i_tx_tready) begin
                        state        <= pio_pkg::TX_IDLE;
                        o_compl_done <= 1'b1;             // Lets the receive side resume
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == pio_pkg::TX_IDLE && i_resp_valid) begin
            data_dw <= i_cpl_addr[2] ? i_resp_data[63:32] : i_resp_data[31:0];
        end
    end

    // Beats depend on the echo fields held by the receive engine
    a_tx_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_tx_tvalid && !i_tx_tready |=> o_tx_tvalid && $stable(o_tx_tdata))
        else $error("completion beat changed under back-pressure");

endmodule

// File: vlog.f
+incdir+verilog
verilog/pio_pkg.sv
verilog/pio_rx_engine.sv
verilog/pio_mem_target.sv
verilog/pio_tx_engine.sv
verilog/pio_top.sv
bench/pio_tb.sv
